// File: compile.f
+incdir+common
common/rv_pkg.sv
mem/data_mem.sv
mem/lsu.sv
hdl/wbu.sv
hdl/reg_file.sv
hdl/rv_tail.sv
test/tb_rv_tail.sv

// File: Makefile
# Verilator build and run of the rv_tail testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_tail
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: simulate clean

# The run passes only if the log holds the pass line
simulate:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_rv_tail.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_tail;

    localparam int CLK_PERIOD = 8;
    localparam int N_SWEEP    = 32;
    localparam int N_ALU      = 40;
    localparam int N_JUMP     = 12;
    localparam int N_MEM      = 6;
    localparam int N_CTRL     = 12;
    localparam int N_X0       = 6;
    localparam int N_DRAIN    = 8;
    localparam int MEM_BYTES  = `RV_DMEM_WORDS * 4;
    // Bubbles included, each memory round issues 21
    localparam int N_INSTS = 2 * N_SWEEP + N_ALU + N_JUMP + 21 * N_MEM + N_CTRL + N_X0 + N_DRAIN;
    localparam int WATCHDOG_NS = (N_INSTS + 4 + 50) * CLK_PERIOD;

    // What write-back should show for one instruction
    typedef struct packed {
        logic              retire;
        rv_pkg::rf_write_s wr;
    } expect_s;

    logic                      clk = 1'b0;
    logic                      arst_n;
    rv_pkg::ex_mem_s           ex;
    logic [`RV_REG_ADDR_W-1:0] rs1_addr;
    logic [`RV_REG_ADDR_W-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    rv_pkg::rf_write_s         wb;
    logic                      retire;

    integer                    seed = 32'hb333_66fa;
    int                        errors = 0;
    int                        checks = 0;
    logic [`RV_REG_ADDR_W-1:0] sweep_addr;

    // Reference state
    logic [7:0]                mem_model [MEM_BYTES];
    logic [`RV_XLEN-1:0]       model_regs [`RV_NUM_REGS];
    expect_s                   exp_issue;
    expect_s                   exp_mem;
    expect_s                   exp_wb;
    expect_s                   exp_done;

    rv_tail dut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .ex_i       (ex),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_o       (wb),
        .retire_o   (retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic log_mismatch(input string msg);
        errors = errors + 1;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic [31:0] make_inst(input rv_pkg::opcode_e opc,
                                              input logic [4:0] rd, input logic [2:0] f3);
        logic [31:0] r;
        r = rand_word();
        make_inst = {r[31:15], f3, rd, opc};
    endfunction

    // Little-endian byte memory
    task automatic store_model(input logic [2:0] f3, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [9:0] a;
        a = addr[9:0];
        case (f3)
            3'b000: mem_model[a] = data[7:0];
            3'b001: begin
                mem_model[{a[9:1], 1'b0}] = data[7:0];
                mem_model[{a[9:1], 1'b1}] = data[15:8];
            end
            3'b010: begin
                for (int k = 0; k < 4; k++) begin
                    mem_model[{a[9:2], k[1:0]}] = data[8*k +: 8];
                end
            end
            default: ;
        endcase
    endtask

    function automatic logic [31:0] load_model(input logic [2:0] f3, input logic [31:0] addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        a = addr[9:0];
        b = mem_model[a];
        h = {mem_model[{a[9:1], 1'b1}], mem_model[{a[9:1], 1'b0}]};
        w = {mem_model[{a[9:2], 2'd3}], mem_model[{a[9:2], 2'd2}],
             mem_model[{a[9:2], 2'd1}], mem_model[{a[9:2], 2'd0}]};
        case (f3)
            3'b000:  load_model = {{24{b[7]}}, b};
            3'b001:  load_model = {{16{h[15]}}, h};
            3'b100:  load_model = {24'd0, b};
            3'b101:  load_model = {16'd0, h};
            default: load_model = w;
        endcase
    endfunction

    // Work out the write-back, then drive after the next edge
    task automatic issue(input logic [31:0] inst, input logic [31:0] pc,
                         input logic [31:0] result, input logic [31:0] sdata);
        expect_s e;
        e = '0;
        e.retire  = (inst != '0);
        e.wr.addr = inst[11:7];
        case (inst[6:0])
            rv_pkg::LUI, rv_pkg::AUIPC, rv_pkg::OP, rv_pkg::OP_IMM: begin
                e.wr.we   = 1'b1;
                e.wr.data = result;
            end
            rv_pkg::JAL, rv_pkg::JALR: begin
                e.wr.we   = 1'b1;
                e.wr.data = pc + 32'd4;
            end
            rv_pkg::LOAD: begin
                e.wr.we   = 1'b1;
                e.wr.data = load_model(inst[14:12], result);
            end
            rv_pkg::STORE: store_model(inst[14:12], result, sdata);
            default: ;
        endcase
        @(posedge clk);
        #1;
        ex.pc         = pc;
        ex.inst       = inst;
        ex.result     = result;
        ex.store_data = sdata;
        exp_issue     = e;
        // Port 1 reads the register just written, port 2 walks the file
        rs1_addr   = exp_done.wr.addr;
        rs2_addr   = sweep_addr;
        sweep_addr = sweep_addr + 5'd1;
    endtask

    task automatic bubble();
        issue('0, '0, '0, '0);
    endtask

    task automatic mem_op(input rv_pkg::opcode_e opc, input logic [2:0] f3,
                          input logic [31:0] addr);
        logic [31:0] r;
        r = rand_word();
        issue(make_inst(opc, r[4:0], f3), rand_word(), addr, rand_word());
    endtask

    task automatic load_all(input logic [31:0] base);
        logic [31:0] r;
        r = rand_word();
        mem_op(rv_pkg::LOAD, 3'b010, base);
        mem_op(rv_pkg::LOAD, 3'b001, base + {30'd0, r[0], 1'b0});
        mem_op(rv_pkg::LOAD, 3'b101, base + {30'd0, r[1], 1'b0});
        mem_op(rv_pkg::LOAD, 3'b000, base + {30'd0, r[3:2]});
        mem_op(rv_pkg::LOAD, 3'b100, base + {30'd0, r[5:4]});
    endtask

    // Expected values follow the pipeline, register model written at edge 3
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_mem  <= '0;
            exp_wb   <= '0;
            exp_done <= '0;
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                model_regs[i] <= '0;
            end
        end else begin
            exp_mem  <= exp_issue;
            exp_wb   <= exp_mem;
            exp_done <= exp_wb;
            if (exp_wb.wr.we && (exp_wb.wr.addr != '0)) begin
                model_regs[exp_wb.wr.addr] <= exp_wb.wr.data;
            end
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            checks = checks + 1;
            assert (retire === exp_wb.retire)
                else log_mismatch($sformatf("retire_o is %0b, expected %0b",
                                            retire, exp_wb.retire));
            assert (wb.we === exp_wb.wr.we)
                else log_mismatch($sformatf("wb_o.we is %0b, expected %0b",
                                            wb.we, exp_wb.wr.we));
            if (exp_wb.wr.we) begin
                assert (wb.addr === exp_wb.wr.addr)
                    else log_mismatch($sformatf("wb_o.addr is %0d, expected %0d",
                                                wb.addr, exp_wb.wr.addr));
                assert (wb.data === exp_wb.wr.data)
                    else log_mismatch($sformatf("wb_o.data is %h, expected %h",
                                                wb.data, exp_wb.wr.data));
            end
            assert (rs1_data === model_regs[rs1_addr])
                else log_mismatch($sformatf("x%0d on port 1 is %h, expected %h",
                                            rs1_addr, rs1_data, model_regs[rs1_addr]));
            assert (rs2_data === model_regs[rs2_addr])
                else log_mismatch($sformatf("x%0d on port 2 is %h, expected %h",
                                            rs2_addr, rs2_data, model_regs[rs2_addr]));
        end
    end

    // A bubble never writes the register file
    assert property (@(negedge clk) disable iff (!arst_n) wb.we |-> retire)
        else log_mismatch("wb_o.we is set while retire_o is low");

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0]     r;
        logic [31:0]     base;
        rv_pkg::opcode_e opc;
        arst_n     = 1'b0;
        ex         = '0;
        rs1_addr   = '0;
        rs2_addr   = '0;
        sweep_addr = '0;
        exp_issue  = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Idle pipeline, every register still zero
        repeat (N_SWEEP) bubble();

        for (int i = 0; i < N_ALU; i++) begin
            case (i[1:0])
                2'd0:    opc = rv_pkg::LUI;
                2'd1:    opc = rv_pkg::AUIPC;
                2'd2:    opc = rv_pkg::OP;
                default: opc = rv_pkg::OP_IMM;
            endcase
            r = rand_word();
            issue(make_inst(opc, r[4:0], r[7:5]), rand_word(), rand_word(), rand_word());
        end

        for (int i = 0; i < N_JUMP; i++) begin
            opc = i[0] ? rv_pkg::JALR : rv_pkg::JAL;
            r   = rand_word();
            issue(make_inst(opc, r[4:0], 3'b000), rand_word() & 32'hffff_fffc,
                  rand_word(), rand_word());
        end

        // Each store gets a bubble before the loads that read it
        for (int i = 0; i < N_MEM; i++) begin
            base = rand_word() & 32'h0000_03fc;
            r    = rand_word();
            mem_op(rv_pkg::STORE, 3'b010, base);
            bubble();
            load_all(base);
            mem_op(rv_pkg::STORE, 3'b001, base + {30'd0, r[0], 1'b0});
            bubble();
            load_all(base);
            mem_op(rv_pkg::STORE, 3'b000, base + {30'd0, r[2:1]});
            bubble();
            load_all(base);
        end

        for (int i = 0; i < N_CTRL; i++) begin
            case (i % 3)
                0:       opc = rv_pkg::BRANCH;
                1:       opc = rv_pkg::STORE;
                default: opc = rv_pkg::SYSTEM;
            endcase
            r = rand_word();
            issue(make_inst(opc, r[4:0], (opc == rv_pkg::STORE) ? 3'b010 : r[7:5]),
                  rand_word(), rand_word() & 32'h0000_03fc, rand_word());
        end
        repeat (N_SWEEP) bubble();

        // Destination x0
        for (int i = 0; i < N_X0; i++) begin
            case (i % 3)
                0:       opc = rv_pkg::LUI;
                1:       opc = rv_pkg::OP;
                default: opc = rv_pkg::JAL;
            endcase
            r = rand_word();
            issue(make_inst(opc, 5'd0, r[7:5]), rand_word(), rand_word(), rand_word());
        end
        repeat (N_DRAIN) bubble();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/rv_tail.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_tail (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  rv_pkg::ex_mem_s           ex_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]       rs1_data_o,
    output logic [`RV_XLEN-1:0]       rs2_data_o,
    output rv_pkg::rf_write_s         wb_o,
    output logic                      retire_o
);

    // Memory stage to data memory
    logic [`RV_XLEN-1:0] mem_addr;
    logic [`RV_BE_W-1:0] mem_be;
    logic [`RV_XLEN-1:0] mem_wdata;
    logic [`RV_XLEN-1:0] mem_rdata;

    rv_pkg::mem_wb_s mem_wb;

    lsu u_lsu (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ex_i        (ex_i),
        .mem_addr_o  (mem_addr),
        .mem_be_o    (mem_be),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .wb_o        (mem_wb)
    );

    data_mem u_data_mem (
        .clk_i   (clk_i),
        .addr_i  (mem_addr),
        .be_i    (mem_be),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    wbu u_wbu (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .mem_i    (mem_wb),
        .wb_o     (wb_o),
        .retire_o (retire_o)
    );

    // Write port is also exported as wb_o
    reg_file u_reg_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wr_i       (wb_o),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module reg_file (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  rv_pkg::rf_write_s         wr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]       rs1_data_o,
    output logic [`RV_XLEN-1:0]       rs2_data_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    // Single write port, x0 never written
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= `RV_RESET_WORD;
            end
        end else if (wr_i.we && (wr_i.addr != '0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Read ports, no bypass from the write port
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: hdl/wbu.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module wbu (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  rv_pkg::mem_wb_s   mem_i,
    output rv_pkg::rf_write_s wb_o,
    output logic              retire_o
);

    rv_pkg::mem_wb_s     mem_q;
    rv_pkg::opcode_e     opcode;
    rv_pkg::wb_sel_e     wb_sel;
    logic                rf_we;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] wb_data;

    // Stage register for every field from the memory stage
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_q <= '0;
        end else begin
            mem_q <= mem_i;
        end
    end

    assign opcode   = rv_pkg::opcode_e'(mem_q.inst[6:0]);
    assign pc_plus4 = mem_q.pc + `RV_PC_STEP;

    // Write enable and source select
    always_comb begin
        case (opcode)
            rv_pkg::LUI,
            rv_pkg::AUIPC,
            rv_pkg::OP,
            rv_pkg::OP_IMM: begin
                rf_we  = 1'b1;
                wb_sel = rv_pkg::WB_RESULT;
            end
            rv_pkg::JAL,
            rv_pkg::JALR: begin
                rf_we  = 1'b1;
                wb_sel = rv_pkg::WB_PC4;
            end
            rv_pkg::LOAD: begin
                rf_we  = 1'b1;
                wb_sel = rv_pkg::WB_LOAD;
            end
            default: begin
                // Branches, stores, system and bubbles
                rf_we  = 1'b0;
                wb_sel = rv_pkg::WB_NONE;
            end
        endcase
    end

    // Result mux
    always_comb begin
        case (wb_sel)
            rv_pkg::WB_PC4:    wb_data = pc_plus4;
            rv_pkg::WB_RESULT: wb_data = mem_q.result;
            rv_pkg::WB_LOAD:   wb_data = mem_q.load_data;
            default:           wb_data = '0;
        endcase
    end

    assign wb_o.we   = rf_we;
    assign wb_o.addr = mem_q.inst[11:7];
    assign wb_o.data = wb_data;

    // A bubble is the all-zero instruction
    assign retire_o = |mem_q.inst;

endmodule

// File: mem/lsu.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module lsu (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  rv_pkg::ex_mem_s     ex_i,
    output logic [`RV_XLEN-1:0] mem_addr_o,
    output logic [`RV_BE_W-1:0] mem_be_o,
    output logic [`RV_XLEN-1:0] mem_wdata_o,
    input  logic [`RV_XLEN-1:0] mem_rdata_i,
    output rv_pkg::mem_wb_s     wb_o
);

    // funct3 encodings for loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    rv_pkg::ex_mem_s     ex_q;
    rv_pkg::opcode_e     opcode;
    logic [2:0]          funct3;
    logic [1:0]          byte_off;

    logic [`RV_BE_W-1:0] store_be;
    logic [`RV_XLEN-1:0] store_word;

    logic [7:0]          load_byte;
    logic [15:0]         load_half;
    logic [`RV_XLEN-1:0] load_data;

    // Stage register, loads every cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_i;
        end
    end

    assign opcode   = rv_pkg::opcode_e'(ex_q.inst[6:0]);
    assign funct3   = ex_q.inst[14:12];
    assign byte_off = ex_q.result[1:0];

    // Store lanes and replicated write word
    always_comb begin
        case (funct3)
            F3_B: begin
                store_be   = 4'b0001 << byte_off;
                store_word = {`RV_BE_W{ex_q.store_data[7:0]}};
            end
            F3_H: begin
                store_be   = byte_off[1] ? 4'b1100 : 4'b0011;
                store_word = {(`RV_BE_W / 2){ex_q.store_data[15:0]}};
            end
            F3_W: begin
                store_be   = 4'b1111;
                store_word = ex_q.store_data;
            end
            default: begin
                // Unsupported store width writes nothing
                store_be   = '0;
                store_word = ex_q.store_data;
            end
        endcase
    end

    assign mem_addr_o  = ex_q.result;
    assign mem_be_o    = (opcode == rv_pkg::STORE) ? store_be : '0;
    assign mem_wdata_o = store_word;

    // Pick the addressed byte and halfword
    assign load_byte = mem_rdata_i[{byte_off, 3'b000} +: 8];
    assign load_half = byte_off[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    // Sign or zero extension by funct3
    always_comb begin
        case (funct3)
            F3_B: begin
                load_data = {{(`RV_XLEN - 8){load_byte[7]}}, load_byte};
            end
            F3_H: begin
                load_data = {{(`RV_XLEN - 16){load_half[15]}}, load_half};
            end
            F3_W: begin
                load_data = mem_rdata_i;
            end
            F3_BU: begin
                load_data = {{(`RV_XLEN - 8){1'b0}}, load_byte};
            end
            F3_HU: begin
                load_data = {{(`RV_XLEN - 16){1'b0}}, load_half};
            end
            default: begin
                load_data = mem_rdata_i;
            end
        endcase
    end

    // Fields handed on to write-back
    assign wb_o.pc        = ex_q.pc;
    assign wb_o.inst      = ex_q.inst;
    assign wb_o.result    = ex_q.result;
    assign wb_o.load_data = load_data;

endmodule

// File: mem/data_mem.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module data_mem (
    input  logic                clk_i,
    input  logic [`RV_XLEN-1:0] addr_i,
    input  logic [`RV_BE_W-1:0] be_i,
    input  logic [`RV_XLEN-1:0] wdata_i,
    output logic [`RV_XLEN-1:0] rdata_o
);

    logic [`RV_XLEN-1:0]       mem [`RV_DMEM_WORDS];
    logic [`RV_DMEM_IDX_W-1:0] word_idx;

    // Byte offset bits are dropped
    assign word_idx = addr_i[`RV_DMEM_IDX_LSB +: `RV_DMEM_IDX_W];

    // One write per enabled byte lane
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < `RV_BE_W; b++) begin
            if (be_i[b]) begin
                mem[word_idx][b*`RV_BYTE_W +: `RV_BYTE_W] <= wdata_i[b*`RV_BYTE_W +: `RV_BYTE_W];
            end
        end
    end

    // Asynchronous read of the whole word
    assign rdata_o = mem[word_idx];

endmodule

// File: common/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // Source of the value written back
    typedef enum logic [1:0] {
        WB_NONE   = 2'b00,
        WB_PC4    = 2'b01,
        WB_RESULT = 2'b10,
        WB_LOAD   = 2'b11
    } wb_sel_e;

    // Execute to memory stage
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] store_data;
    } ex_mem_s;

    // Memory to write-back stage
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] load_data;
    } mem_wb_s;

    // Register file write port
    typedef struct packed {
        logic                      we;
        logic [`RV_REG_ADDR_W-1:0] addr;
        logic [`RV_XLEN-1:0]       data;
    } rf_write_s;

endpackage

// File: common/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath and address width
`define RV_XLEN        32
`define RV_BYTE_W      8
`define RV_BE_W        4

// Integer register file
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32

// Data memory, word organised
`define RV_DMEM_WORDS   256
`define RV_DMEM_IDX_W   8
// Word index starts above the byte offset
`define RV_DMEM_IDX_LSB 2

// Sequential PC increment
`define RV_PC_STEP     4

// Register contents after reset
`define RV_RESET_WORD  {`RV_XLEN{1'b0}}

`endif
